/* verilog/chan_config.svh */
`ifndef CHAN_CONFIG_SVH
`define CHAN_CONFIG_SVH

// datapath widths
`define CHAN_DATA_W 32
`define CHAN_ADDR_W 32
`define CHAN_MSG_W 8
`define CHAN_STATE_W 8

// thread header size, taken off both bases for the thread address
`define CHAN_HEADER_SPACE 32'd64

// processor state codes
`define CHAN_ST_ALU_BEGIN 8'h04
`define CHAN_ST_FINISH_END 8'h0c

// channel instruction opcode
`define CHAN_CMD_CHN 4'hc

// messages sent to the dispatcher
`define CHAN_MSG_SET 8'h30
`define CHAN_MSG_GET 8'h31
`define CHAN_MSG_THREAD_ADDR 8'h32

// replies from the dispatcher
`define CHAN_MSG_ACCEPTED 8'h40
`define CHAN_MSG_NO_RESULTS 8'h41
`define CHAN_MSG_RES_RD 8'h42
`define CHAN_MSG_RES_WR 8'h43

`endif

/* verilog/chan_pkg.sv */
`include "chan_config.svh"

package chan_pkg;

  // instruction word, msb first
  // a register field of 2'b11 means the register is unused
  typedef struct packed {
    logic [3:0]  opcode;
    logic [1:0]  cond;
    logic [1:0]  dst;
    logic [1:0]  src0;
    logic [1:0]  src1;
    logic [19:0] rest;
  } chan_cmd_t;

  // dispatcher message, same layout both ways
  typedef struct packed {
    logic [`CHAN_MSG_W-1:0]  code;
    logic [`CHAN_ADDR_W-1:0] addr;
    logic [`CHAN_DATA_W-1:0] data;
  } chan_msg_t;

  // decoded channel operation
  typedef enum logic [1:0] {
    CHAN_OP_NONE,
    CHAN_OP_GET,
    CHAN_OP_SET,
    CHAN_OP_CONV
  } chan_op_e;

  // reply classification, rx to ctrl
  // result means read result for a get, write result for a set
  typedef enum logic [1:0] {
    CHAN_REPLY_NONE,
    CHAN_REPLY_ACCEPTED,
    CHAN_REPLY_NO_RESULTS,
    CHAN_REPLY_RESULT
  } chan_reply_e;

endpackage

/* verilog/chan_ctrl.sv */
`timescale 1ns/1ps
`include "chan_config.svh"

module chan_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  chan_pkg::chan_cmd_t      command_i,
  input  logic [`CHAN_STATE_W-1:0] state_i,
  input  logic                     disp_online_i,
  input  chan_pkg::chan_reply_e    reply_kind_i,
  output logic                     send_req_o,
  output logic                     send_thread_o,
  output logic                     op_set_o,
  output logic                     listen_o,
  output logic                     load_conv_o,
  output logic                     clear_dst_o,
  output logic                     clear_flags_o,
  output logic                     chan_op_o,
  output logic                     chan_strb_o,
  output logic                     next_state_o
);

  // one gap after each outgoing message
  typedef enum logic [2:0] {
    ST_IDLE, ST_REQ, ST_GAP_REQ, ST_THREAD,
    ST_GAP_THREAD, ST_LISTEN, ST_SETTLE, ST_RETIRE
  } fsm_e;

  fsm_e                fsm_q;
  logic [2:0]          en_pattern;
  logic                in_alu_begin;
  logic                chan_go;
  logic                op_set_q;
  chan_pkg::chan_op_e  op_dec;

  // enables in order dst, src0, src1
  assign en_pattern   = {~&command_i.dst, ~&command_i.src0, ~&command_i.src1};
  assign in_alu_begin = (state_i == `CHAN_ST_ALU_BEGIN);
  assign chan_go      = in_alu_begin && (command_i.opcode == `CHAN_CMD_CHN) && disp_online_i;

  always_comb begin
    op_dec = chan_pkg::CHAN_OP_NONE;
    if (command_i.opcode == `CHAN_CMD_CHN) begin
      case (en_pattern)
        3'b110:  op_dec = chan_pkg::CHAN_OP_GET;
        3'b011:  op_dec = chan_pkg::CHAN_OP_SET;
        3'b101:  op_dec = chan_pkg::CHAN_OP_CONV;
        default: op_dec = chan_pkg::CHAN_OP_NONE;
      endcase
    end
  end

  // request goes out on the start edge, thread address after the first gap
  assign send_req_o    = (fsm_q == ST_IDLE) && chan_go &&
                         (op_dec == chan_pkg::CHAN_OP_GET || op_dec == chan_pkg::CHAN_OP_SET);
  assign send_thread_o = (fsm_q == ST_GAP_REQ);
  // live decode on the start edge, latched copy afterwards
  assign op_set_o      = (fsm_q == ST_IDLE) ? (op_dec == chan_pkg::CHAN_OP_SET) : op_set_q;
  assign listen_o      = (fsm_q == ST_LISTEN);
  assign load_conv_o   = (fsm_q == ST_IDLE) && chan_go && (op_dec == chan_pkg::CHAN_OP_CONV);
  assign clear_dst_o   = !in_alu_begin;
  assign clear_flags_o = (state_i == `CHAN_ST_FINISH_END);

  always_ff @(posedge clk) begin
    if (rst) begin
      fsm_q        <= ST_IDLE;
      op_set_q     <= 1'b0;
      chan_op_o    <= 1'b0;
      chan_strb_o  <= 1'b0;
      next_state_o <= 1'b0;
    end else begin
      // single-cycle pulses by default
      chan_op_o    <= 1'b0;
      next_state_o <= 1'b0;
      case (fsm_q)
        ST_IDLE: begin
          if (chan_go) begin
            case (op_dec)
              chan_pkg::CHAN_OP_GET, chan_pkg::CHAN_OP_SET: begin
                op_set_q    <= (op_dec == chan_pkg::CHAN_OP_SET);
                chan_op_o   <= 1'b1;
                chan_strb_o <= 1'b1;
                fsm_q       <= ST_REQ;
              end
              chan_pkg::CHAN_OP_CONV: begin
                chan_op_o    <= 1'b1;
                next_state_o <= 1'b1;
                fsm_q        <= ST_RETIRE;
              end
              default: begin
                // unsupported pattern, just move on
                next_state_o <= 1'b1;
                fsm_q        <= ST_RETIRE;
              end
            endcase
          end
        end
        ST_REQ: fsm_q <= ST_GAP_REQ;
        ST_GAP_REQ: begin
          chan_op_o <= 1'b1;
          fsm_q     <= ST_THREAD;
        end
        ST_THREAD: fsm_q <= ST_GAP_THREAD;
        ST_GAP_THREAD: begin
          chan_strb_o <= 1'b0;
          fsm_q       <= ST_LISTEN;
        end
        ST_LISTEN: begin
          // no timeout, wait for the dispatcher as long as it takes
          case (reply_kind_i)
            chan_pkg::CHAN_REPLY_RESULT: begin
              next_state_o <= 1'b1;
              fsm_q        <= ST_RETIRE;
            end
            chan_pkg::CHAN_REPLY_ACCEPTED, chan_pkg::CHAN_REPLY_NO_RESULTS: begin
              fsm_q <= ST_SETTLE;
            end
            default: fsm_q <= ST_LISTEN;
          endcase
        end
        ST_SETTLE: begin
          // flag was set last edge
          next_state_o <= 1'b1;
          fsm_q        <= ST_RETIRE;
        end
        ST_RETIRE: begin
          // block a second start until the processor moves on
          if (!in_alu_begin) begin
            fsm_q <= ST_IDLE;
          end
        end
        default: fsm_q <= ST_IDLE;
      endcase
    end
  end

endmodule

/* verilog/chan_msg_tx.sv */
`timescale 1ns/1ps
`include "chan_config.svh"

module chan_msg_tx (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    send_req_i,
  input  logic                    send_thread_i,
  input  logic                    op_set_i,
  input  logic [`CHAN_DATA_W-1:0] src0_i,
  input  logic [`CHAN_DATA_W-1:0] src1_i,
  input  logic [`CHAN_ADDR_W-1:0] base_addr_i,
  input  logic [`CHAN_ADDR_W-1:0] base_addr_data_i,
  output chan_pkg::chan_msg_t     msg_o,
  output logic                    msg_pulse_o
);

  chan_pkg::chan_msg_t req_msg;
  chan_pkg::chan_msg_t thread_msg;
  chan_pkg::chan_msg_t msg_q;
  // covers the gap cycle after a send
  logic                gap_hold_q;

  // request, set carries src1 as data
  always_comb begin
    req_msg.code = op_set_i ? `CHAN_MSG_SET : `CHAN_MSG_GET;
    req_msg.addr = src0_i;
    req_msg.data = op_set_i ? src1_i : '0;
  end

  // thread address, both bases minus header
  always_comb begin
    thread_msg.code = `CHAN_MSG_THREAD_ADDR;
    thread_msg.addr = base_addr_i - `CHAN_HEADER_SPACE;
    thread_msg.data = base_addr_data_i - `CHAN_HEADER_SPACE;
  end

  // payload register
  always_ff @(posedge clk) begin
    if (send_req_i) begin
      msg_q <= req_msg;
    end else if (send_thread_i) begin
      msg_q <= thread_msg;
    end
  end

  // pulse high on send, through the gap, low the edge after
  always_ff @(posedge clk) begin
    if (rst) begin
      msg_pulse_o <= 1'b0;
      gap_hold_q  <= 1'b0;
    end else if (send_req_i || send_thread_i) begin
      msg_pulse_o <= 1'b1;
      gap_hold_q  <= 1'b1;
    end else if (gap_hold_q) begin
      gap_hold_q  <= 1'b0;
    end else begin
      msg_pulse_o <= 1'b0;
    end
  end

  // all fields read zero outside the pulse
  assign msg_o = msg_pulse_o ? msg_q : '0;

endmodule

/* verilog/chan_reply_rx.sv */
`timescale 1ns/1ps
`include "chan_config.svh"

module chan_reply_rx (
  input  logic                    clk,
  input  logic                    rst,
  input  chan_pkg::chan_msg_t     reply_i,
  input  logic                    listen_i,
  input  logic                    op_set_i,
  input  logic                    load_conv_i,
  input  logic                    clear_dst_i,
  input  logic                    clear_flags_i,
  input  logic [`CHAN_DATA_W-1:0] src1_i,
  input  logic [`CHAN_ADDR_W-1:0] base_addr_data_i,
  output chan_pkg::chan_reply_e   reply_kind_o,
  output logic [`CHAN_DATA_W-1:0] dst_o,
  output logic                    escape_o,
  output logic                    wait_next_o
);

  logic [`CHAN_DATA_W-1:0] conv_sum;
  logic                    load_rd;

  // channel number conversion
  assign conv_sum = src1_i + base_addr_data_i;

  // classify only while listening
  // wrong-direction result is ignored
  always_comb begin
    reply_kind_o = chan_pkg::CHAN_REPLY_NONE;
    if (listen_i) begin
      case (reply_i.code)
        `CHAN_MSG_ACCEPTED:   reply_kind_o = chan_pkg::CHAN_REPLY_ACCEPTED;
        `CHAN_MSG_NO_RESULTS: reply_kind_o = chan_pkg::CHAN_REPLY_NO_RESULTS;
        `CHAN_MSG_RES_RD: begin
          if (!op_set_i) reply_kind_o = chan_pkg::CHAN_REPLY_RESULT;
        end
        `CHAN_MSG_RES_WR: begin
          if (op_set_i) reply_kind_o = chan_pkg::CHAN_REPLY_RESULT;
        end
        default: reply_kind_o = chan_pkg::CHAN_REPLY_NONE;
      endcase
    end
  end

  // read data only lands for a get
  assign load_rd = (reply_kind_o == chan_pkg::CHAN_REPLY_RESULT) && !op_set_i;

  always_ff @(posedge clk) begin
    if (rst || clear_dst_i) begin
      dst_o <= '0;
    end else if (load_conv_i) begin
      dst_o <= conv_sum;
    end else if (load_rd) begin
      dst_o <= reply_i.data;
    end
  end

  // escape / wait flags, set by reply, dropped in finish
  always_ff @(posedge clk) begin
    if (rst || clear_flags_i) begin
      escape_o    <= 1'b0;
      wait_next_o <= 1'b0;
    end else begin
      if (reply_kind_o == chan_pkg::CHAN_REPLY_ACCEPTED) escape_o <= 1'b1;
      if (reply_kind_o == chan_pkg::CHAN_REPLY_NO_RESULTS) wait_next_o <= 1'b1;
    end
  end

endmodule

/* verilog/chan_unit.sv */
`timescale 1ns/1ps
`include "chan_config.svh"

module chan_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  chan_pkg::chan_cmd_t      command_i,
  input  logic [`CHAN_STATE_W-1:0] state_i,
  input  logic                     disp_online_i,
  input  logic [`CHAN_DATA_W-1:0]  src1_i,
  input  logic [`CHAN_DATA_W-1:0]  src0_i,
  input  logic [`CHAN_ADDR_W-1:0]  base_addr_i,
  input  logic [`CHAN_ADDR_W-1:0]  base_addr_data_i,
  input  chan_pkg::chan_msg_t      reply_i,
  output chan_pkg::chan_msg_t      msg_o,
  output logic                     msg_pulse_o,
  output logic                     chan_strb_o,
  output logic                     chan_op_o,
  output logic                     next_state_o,
  output logic [`CHAN_DATA_W-1:0]  dst_o,
  output logic                     escape_o,
  output logic                     wait_next_o
);

  // ctrl to datapath
  logic send_req;
  logic send_thread;
  logic op_set;
  logic listen;
  logic load_conv;
  logic clear_dst;
  logic clear_flags;
  // rx back to ctrl
  chan_pkg::chan_reply_e reply_kind;

  chan_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .command_i     (command_i),
    .state_i       (state_i),
    .disp_online_i (disp_online_i),
    .reply_kind_i  (reply_kind),
    .send_req_o    (send_req),
    .send_thread_o (send_thread),
    .op_set_o      (op_set),
    .listen_o      (listen),
    .load_conv_o   (load_conv),
    .clear_dst_o   (clear_dst),
    .clear_flags_o (clear_flags),
    .chan_op_o     (chan_op_o),
    .chan_strb_o   (chan_strb_o),
    .next_state_o  (next_state_o)
  );

  chan_msg_tx u_msg_tx (
    .clk              (clk),
    .rst              (rst),
    .send_req_i       (send_req),
    .send_thread_i    (send_thread),
    .op_set_i         (op_set),
    .src0_i           (src0_i),
    .src1_i           (src1_i),
    .base_addr_i      (base_addr_i),
    .base_addr_data_i (base_addr_data_i),
    .msg_o            (msg_o),
    .msg_pulse_o      (msg_pulse_o)
  );

  chan_reply_rx u_reply_rx (
    .clk              (clk),
    .rst              (rst),
    .reply_i          (reply_i),
    .listen_i         (listen),
    .op_set_i         (op_set),
    .load_conv_i      (load_conv),
    .clear_dst_i      (clear_dst),
    .clear_flags_i    (clear_flags),
    .src1_i           (src1_i),
    .base_addr_data_i (base_addr_data_i),
    .reply_kind_o     (reply_kind),
    .dst_o            (dst_o),
    .escape_o         (escape_o),
    .wait_next_o      (wait_next_o)
  );

endmodule

/* verification/chan_assertions.sv */
`timescale 1ns/1ps
`include "chan_config.svh"

module chan_assertions (
  input logic                     clk,
  input logic                     rst,
  input logic [`CHAN_STATE_W-1:0] state_i,
  input logic                     disp_online_i,
  input chan_pkg::chan_msg_t      msg_o,
  input logic                     msg_pulse_o,
  input logic                     chan_strb_o,
  input logic                     chan_op_o,
  input logic                     next_state_o,
  input logic                     escape_o,
  input logic                     wait_next_o
);

  // count of failed properties
  int unsigned fail_count = 0;

  // message fields gated by the pulse
  msg_gated: assert property (@(posedge clk) disable iff (rst)
    !msg_pulse_o |-> msg_o == '0)
    else begin
      fail_count++;
      $error("message fields not zero with the pulse low");
    end

  // a message only goes out inside the strobe window
  pulse_in_strobe: assert property (@(posedge clk) disable iff (rst)
    msg_pulse_o |-> chan_strb_o)
    else begin
      fail_count++;
      $error("message pulse outside the channel strobe");
    end

  // exchange only starts with the dispatcher online
  strobe_online: assert property (@(posedge clk) disable iff (rst)
    $rose(chan_strb_o) |-> $past(disp_online_i))
    else begin
      fail_count++;
      $error("channel strobe rose with the dispatcher offline");
    end

  // single-cycle pulses
  next_state_once: assert property (@(posedge clk) disable iff (rst)
    next_state_o |=> !next_state_o)
    else begin
      fail_count++;
      $error("next_state_o held for more than one cycle");
    end

  chan_op_once: assert property (@(posedge clk) disable iff (rst)
    chan_op_o |=> !chan_op_o)
    else begin
      fail_count++;
      $error("chan_op_o held for more than one cycle");
    end

  // finish-end drops both flags on the next edge
  finish_clears: assert property (@(posedge clk) disable iff (rst)
    state_i == `CHAN_ST_FINISH_END |=> !escape_o && !wait_next_o)
    else begin
      fail_count++;
      $error("escape or wait flag survived finish-end");
    end

endmodule

/* verification/chan_tb.sv */
`timescale 1ns/1ps
`include "chan_config.svh"

module chan_tb;

  logic                     clk;
  logic                     rst;
  chan_pkg::chan_cmd_t      command_i;
  logic [`CHAN_STATE_W-1:0] state_i;
  logic                     disp_online_i;
  logic [`CHAN_DATA_W-1:0]  src1_i;
  logic [`CHAN_DATA_W-1:0]  src0_i;
  logic [`CHAN_ADDR_W-1:0]  base_addr_i;
  logic [`CHAN_ADDR_W-1:0]  base_addr_data_i;
  chan_pkg::chan_msg_t      reply_i;
  chan_pkg::chan_msg_t      msg_o;
  logic                     msg_pulse_o;
  logic                     chan_strb_o;
  logic                     chan_op_o;
  logic                     next_state_o;
  logic [`CHAN_DATA_W-1:0]  dst_o;
  logic                     escape_o;
  logic                     wait_next_o;
  logic [31:0]              lfsr_q;

  chan_unit dut (.*);

  // protocol checks ride along inside the DUT
  bind chan_unit chan_assertions chk (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic mismatch(input string what);
    fail_run($sformatf("Mismatch at %0t ns: %s", $time, what));
  endtask

  // 32-bit fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // pattern bits dst, src0, src1; 2'b11 marks an unused register
  function automatic chan_pkg::chan_cmd_t make_cmd(input logic [2:0] pattern);
    chan_pkg::chan_cmd_t c;
    c        = '0;
    c.opcode = `CHAN_CMD_CHN;
    c.dst    = pattern[2] ? 2'b00 : 2'b11;
    c.src0   = pattern[1] ? 2'b01 : 2'b11;
    c.src1   = pattern[0] ? 2'b10 : 2'b11;
    return c;
  endfunction

  // one instruction from alu-begin through finish-end, dispatcher included
  task automatic run_op(input logic [2:0] pattern, input logic [7:0] rcode,
                        input logic wrong_first);
    logic [31:0]         s0;
    logic [31:0]         s1;
    logic [31:0]         ba;
    logic [31:0]         bad;
    logic [31:0]         rdata;
    logic [31:0]         d;
    logic [31:0]         dst_before;
    logic [7:0]          last_code;
    logic [2:0]          delay;
    logic                is_set;
    logic                wrong_left;
    logic                listening;
    logic                presented;
    logic                prev_escape;
    logic                prev_wait;
    chan_pkg::chan_msg_t r;
    int                  msgs;
    int                  cycles;
    int                  ops;
    take_bits(32, s0);
    take_bits(32, s1);
    take_bits(32, ba);
    take_bits(32, bad);
    take_bits(32, rdata);
    is_set      = (pattern == 3'b011);
    wrong_left  = wrong_first;
    last_code   = 8'h00;
    delay       = 3'd0;
    listening   = 1'b0;
    presented   = 1'b0;
    prev_escape = 1'b0;
    prev_wait   = 1'b0;
    dst_before  = '0;
    msgs        = 0;
    cycles      = 0;
    ops         = 0;
    @(posedge clk);
    command_i        <= make_cmd(pattern);
    state_i          <= `CHAN_ST_ALU_BEGIN;
    src0_i           <= s0;
    src1_i           <= s1;
    base_addr_i      <= ba;
    base_addr_data_i <= bad;
    forever begin
      @(negedge clk);
      cycles++;
      if (cycles > 64) fail_run("timed out waiting for next_state_o");
      if (cycles == 1) dst_before = dst_o;
      if (!msg_pulse_o) begin
        assert (msg_o == '0) else mismatch("message fields not zero with the pulse low");
        // thread address gone, dispatcher starts its reply delay
        if (last_code == `CHAN_MSG_THREAD_ADDR && !listening) begin
          assert (!chan_strb_o) else mismatch("chan_strb_o still high after the exchange");
          listening = 1'b1;
          take_bits(3, d);
          delay = d[2:0];
        end
      end else if (msg_o.code != last_code) begin
        msgs++;
        last_code = msg_o.code;
        // every new message comes with a chan_op_o pulse
        assert (chan_op_o) else mismatch("chan_op_o not pulsed with a new message");
        if (last_code == `CHAN_MSG_THREAD_ADDR) begin
          assert (msg_o.addr == ba - `CHAN_HEADER_SPACE && msg_o.data == bad - `CHAN_HEADER_SPACE)
            else mismatch("thread address message");
        end else begin
          assert (msg_o.code == (is_set ? `CHAN_MSG_SET : `CHAN_MSG_GET) && msg_o.addr == s0 &&
                  (!is_set || msg_o.data == s1))
            else mismatch("request message");
        end
      end
      // one pulse per step that sends or computes
      if (chan_op_o) ops++;
      if (next_state_o) break;
      prev_escape = escape_o;
      prev_wait   = wait_next_o;
      @(posedge clk);
      if (listening && !presented) begin
        if (delay != 3'd0) begin
          delay--;
        end else begin
          // a write result to a get must be ignored
          r.code  = wrong_left ? `CHAN_MSG_RES_WR : rcode;
          r.addr  = '0;
          r.data  = rdata;
          reply_i <= r;
          presented  = !wrong_left;
          delay      = wrong_left ? 3'd2 : 3'd0;
          wrong_left = 1'b0;
        end
      end
    end
    if (pattern == 3'b110 || is_set) begin
      assert (presented && msgs == 2) else mismatch("next_state_o without a full exchange");
      assert (ops == 2) else mismatch("chan_op_o pulses over a channel exchange");
      if (rcode == `CHAN_MSG_RES_RD)
        assert (dst_o == rdata) else mismatch("dst_o does not hold the read data");
      if (rcode == `CHAN_MSG_ACCEPTED)
        assert (prev_escape && escape_o) else mismatch("escape_o not raised before next_state_o");
      if (rcode == `CHAN_MSG_NO_RESULTS)
        assert (prev_wait && wait_next_o && dst_o == dst_before)
          else mismatch("no results reply handled wrongly");
    end else begin
      assert (msgs == 0 && !chan_strb_o) else mismatch("message sent for a local instruction");
      assert (ops == ((pattern == 3'b101) ? 1 : 0))
        else mismatch("chan_op_o pulses for a local instruction");
      if (pattern == 3'b101)
        assert (dst_o == s1 + bad) else mismatch("converted channel number");
    end
    @(posedge clk);
    state_i <= `CHAN_ST_FINISH_END;
    reply_i <= '0;
    @(posedge clk);
    @(negedge clk);
    assert (!escape_o && !wait_next_o) else mismatch("flags not cleared in finish-end");
    @(posedge clk);
    // any code other than alu-begin or finish-end
    state_i <= 8'h00;
  endtask

  // dispatcher offline, nothing may start
  task automatic run_offline();
    @(posedge clk);
    disp_online_i <= 1'b0;
    command_i     <= make_cmd(3'b110);
    state_i       <= `CHAN_ST_ALU_BEGIN;
    for (int i = 0; i < 12; i++) begin
      @(negedge clk);
      assert (!msg_pulse_o && !chan_strb_o && !next_state_o)
        else mismatch("activity with the dispatcher offline");
    end
    @(posedge clk);
    state_i       <= 8'h00;
    disp_online_i <= 1'b1;
  endtask

  // stop at the first bound assertion failure
  always @(negedge clk) begin
    if (dut.chk.fail_count != 0) fail_run("a protocol assertion failed");
  end

  initial begin
    rst              = 1'b1;
    command_i        = '0;
    state_i          = 8'h00;
    disp_online_i    = 1'b1;
    src1_i           = '0;
    src0_i           = '0;
    base_addr_i      = '0;
    base_addr_data_i = '0;
    reply_i          = '0;
    lfsr_q           = 32'd97746;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (!next_state_o && !chan_op_o && !msg_pulse_o && !chan_strb_o && !escape_o &&
            !wait_next_o && dst_o == '0)
      else mismatch("outputs not idle after reset");
    run_op(3'b101, 8'h00, 1'b0);
    run_op(3'b110, `CHAN_MSG_RES_RD, 1'b1);
    run_op(3'b011, `CHAN_MSG_ACCEPTED, 1'b0);
    run_op(3'b110, `CHAN_MSG_NO_RESULTS, 1'b0);
    run_op(3'b011, `CHAN_MSG_NO_RESULTS, 1'b0);
    run_op(3'b011, `CHAN_MSG_RES_WR, 1'b0);
    run_op(3'b111, 8'h00, 1'b0);
    run_offline();
    // more reply delays after the offline spell
    for (int i = 0; i < 4; i++) begin
      run_op(3'b110, `CHAN_MSG_RES_RD, 1'b0);
    end
    if (dut.chk.fail_count == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      fail_run("a protocol assertion failed");
    end
  end

endmodule

/* files.f */
+incdir+verilog
verilog/chan_pkg.sv
verilog/chan_ctrl.sv
verilog/chan_msg_tx.sv
verilog/chan_reply_rx.sv
verilog/chan_unit.sv
verification/chan_assertions.sv
verification/chan_tb.sv

/* Makefile */
SIM       ?= verilator
SIM_FLAGS ?= --binary --assert --timing
TOP       ?= chan_tb
FILE_LIST ?= files.f
LOG       ?= sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
